// ==== rtl/bpu_pkg.sv ====
package bpu_pkg;

  // core data and pc width
  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [31:0]     inst_t;

  // resolved jump kind from execute, high to low: call, ret, jal, jalr, branch
  typedef logic [4:0] jump_type_t;

  localparam int JT_BRANCH = 0;
  localparam int JT_JALR   = 1;
  localparam int JT_JAL    = 2;

  // major opcodes of the control transfer instructions
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;

  // two-bit saturating counter, msb set means predict taken
  typedef enum logic [1:0] {
    strong_nt = 2'b00,
    weak_nt   = 2'b01,
    weak_t    = 2'b10,
    strong_t  = 2'b11
  } bht_state_e;

endpackage

// ==== rtl/bpu_update_if.sv ====
`timescale 1ns/1ps

// training traffic from the execute stage into the history table
// an update is taken in the cycle upd_valid is high, the table never refuses
interface bpu_update_if;

  logic            upd_valid;
  bpu_pkg::xlen_t  upd_pc;
  logic            upd_taken;
  logic            upd_is_branch;

  modport src (
    output upd_valid,
    output upd_pc,
    output upd_taken,
    output upd_is_branch
  );

  modport dst (
    input upd_valid,
    input upd_pc,
    input upd_taken,
    input upd_is_branch
  );

endinterface

// ==== rtl/bpu_branch.sv ====
`timescale 1ns/1ps

module bpu_branch #(
  parameter int BHT_NUM = 64
) (
  input  logic             clk,
  input  logic             reset_i,
  input  bpu_pkg::xlen_t   lookup_pc_i,
  input  logic             is_branch_i,
  output logic             taken_o,
  output logic             hit_o,
  bpu_update_if.dst        upd
);

  localparam int IDX_W = $clog2(BHT_NUM);
  localparam int TAG_W = 8;

  logic [BHT_NUM-1:0]  valid_q;
  logic [TAG_W-1:0]    tag_q [BHT_NUM];
  bpu_pkg::bht_state_e cnt_q [BHT_NUM];

  logic [IDX_W-1:0] lk_idx;
  logic [TAG_W-1:0] lk_tag;
  logic [IDX_W-1:0] up_idx;
  logic [TAG_W-1:0] up_tag;
  logic             up_hit;
  logic             up_en;

  // index sits right above the word offset, the tag follows it
  assign lk_idx = lookup_pc_i[IDX_W+1:2];
  assign lk_tag = lookup_pc_i[IDX_W+TAG_W+1:IDX_W+2];
  assign up_idx = upd.upd_pc[IDX_W+1:2];
  assign up_tag = upd.upd_pc[IDX_W+TAG_W+1:IDX_W+2];

  // zero latency lookup, sees the state before this cycle's update
  assign hit_o   = is_branch_i & valid_q[lk_idx] & (tag_q[lk_idx] == lk_tag);
  assign taken_o = hit_o & ((cnt_q[lk_idx] == bpu_pkg::weak_t) ||
                            (cnt_q[lk_idx] == bpu_pkg::strong_t));

  assign up_en  = upd.upd_valid & upd.upd_is_branch;
  assign up_hit = valid_q[up_idx] & (tag_q[up_idx] == up_tag);

  // one step toward the resolved direction, saturating at both ends
  function automatic bpu_pkg::bht_state_e next_cnt(input bpu_pkg::bht_state_e cur,
                                                   input logic taken);
    bpu_pkg::bht_state_e nxt;
    nxt = cur;
    case (cur)
      bpu_pkg::strong_nt: nxt = taken ? bpu_pkg::weak_nt  : bpu_pkg::strong_nt;
      bpu_pkg::weak_nt:   nxt = taken ? bpu_pkg::weak_t   : bpu_pkg::strong_nt;
      bpu_pkg::weak_t:    nxt = taken ? bpu_pkg::strong_t : bpu_pkg::weak_nt;
      bpu_pkg::strong_t:  nxt = taken ? bpu_pkg::strong_t : bpu_pkg::weak_t;
      default:            nxt = bpu_pkg::weak_nt;
    endcase
    return nxt;
  endfunction

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= '0;
    end else if (up_en) begin
      valid_q[up_idx] <= 1'b1;
    end
  end

  // a miss allocates the entry in the weak state of the outcome
  always_ff @(posedge clk) begin
    if (up_en) begin
      tag_q[up_idx] <= up_tag;
      if (up_hit) begin
        cnt_q[up_idx] <= next_cnt(cnt_q[up_idx], upd.upd_taken);
      end else begin
        cnt_q[up_idx] <= upd.upd_taken ? bpu_pkg::weak_t : bpu_pkg::weak_nt;
      end
    end
  end

endmodule

// ==== rtl/bpu_predict.sv ====
`timescale 1ns/1ps

module bpu_predict #(
  parameter int BHT_NUM = 64
) (
  input  logic                 clk,
  input  logic                 reset_i,
  input  bpu_pkg::inst_t       inst_data_i,
  input  bpu_pkg::xlen_t       pc_if_i,
  input  bpu_pkg::xlen_t       update_pc_i,
  input  logic                 update_valid_i,
  input  logic                 update_taken_i,
  input  bpu_pkg::jump_type_t  update_jump_type_i,
  output logic                 pred_valid_o,
  output bpu_pkg::xlen_t       pred_op1_o,
  output bpu_pkg::xlen_t       pred_op2_o
);

  localparam int XLEN = bpu_pkg::XLEN;

  logic [6:0]     opcode;
  logic [4:0]     rs1;
  logic           type_branch;
  logic           type_jal;
  logic           type_jalr;
  bpu_pkg::xlen_t imm_i;
  bpu_pkg::xlen_t imm_b;
  bpu_pkg::xlen_t imm_j;
  logic           bht_taken;
  logic           bht_hit;
  logic           branch_taken;

  assign opcode = inst_data_i[6:0];
  assign rs1    = inst_data_i[19:15];

  assign type_branch = (opcode == bpu_pkg::OPC_BRANCH);
  assign type_jalr   = (opcode == bpu_pkg::OPC_JALR);
  assign type_jal    = (opcode == bpu_pkg::OPC_JAL);

  // sign-extended immediates of the I, B and J formats
  assign imm_i = {{(XLEN-12){inst_data_i[31]}}, inst_data_i[31:20]};
  assign imm_b = {{(XLEN-12){inst_data_i[31]}}, inst_data_i[7], inst_data_i[30:25],
                  inst_data_i[11:8], 1'b0};
  assign imm_j = {{(XLEN-20){inst_data_i[31]}}, inst_data_i[19:12], inst_data_i[20],
                  inst_data_i[30:21], 1'b0};

  // execute-stage training, only the branch bit matters to the table
  bpu_update_if upd_bus ();

  assign upd_bus.upd_valid     = update_valid_i;
  assign upd_bus.upd_pc        = update_pc_i;
  assign upd_bus.upd_taken     = update_taken_i;
  assign upd_bus.upd_is_branch = update_jump_type_i[bpu_pkg::JT_BRANCH];

  bpu_branch #(
    .BHT_NUM (BHT_NUM)
  ) u_bpu_branch (
    .clk         (clk),
    .reset_i     (reset_i),
    .lookup_pc_i (pc_if_i),
    .is_branch_i (type_branch),
    .taken_o     (bht_taken),
    .hit_o       (bht_hit),
    .upd         (upd_bus)
  );

  // table miss falls back to backward taken, forward not taken
  assign branch_taken = bht_hit ? bht_taken : imm_b[XLEN-1];

  // jalr is only resolvable here when the base register is x0
  assign pred_valid_o = (type_branch & branch_taken)
                      | type_jal
                      | (type_jalr & (rs1 == 5'd0));

  assign pred_op1_o = (type_branch | type_jal) ? pc_if_i : '0;

  always_comb begin
    pred_op2_o = '0;
    if (type_branch) begin
      pred_op2_o = imm_b;
    end else if (type_jal) begin
      pred_op2_o = imm_j;
    end else if (type_jalr) begin
      pred_op2_o = imm_i;
    end
  end

endmodule

// ==== rtl/fetch_pc_gen.sv ====
`timescale 1ns/1ps

module fetch_pc_gen #(
  parameter bpu_pkg::xlen_t RESET_PC = 64'h8000_0000
) (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            step_i,
  input  logic            redirect_valid_i,
  input  bpu_pkg::xlen_t  redirect_pc_i,
  input  logic            pred_valid_i,
  input  bpu_pkg::xlen_t  pred_op1_i,
  input  bpu_pkg::xlen_t  pred_op2_i,
  output bpu_pkg::xlen_t  pc_o
);

  bpu_pkg::xlen_t pc_q;
  bpu_pkg::xlen_t pred_target;
  bpu_pkg::xlen_t seq_pc;
  bpu_pkg::xlen_t pc_d;

  // predicted target, pc+imm or x0+imm depending on the jump kind
  assign pred_target = pred_op1_i + pred_op2_i;
  assign seq_pc      = pc_q + 64'd4;

  // redirect wins over everything and does not wait for a step
  always_comb begin
    pc_d = pc_q;
    if (redirect_valid_i) begin
      pc_d = redirect_pc_i;
    end else if (step_i) begin
      if (pred_valid_i) begin
        pc_d = pred_target;
      end else begin
        pc_d = seq_pc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

endmodule

// ==== rtl/bpu_frontend_top.sv ====
`timescale 1ns/1ps

module bpu_frontend_top #(
  parameter int             BHT_NUM  = 64,
  parameter bpu_pkg::xlen_t RESET_PC = 64'h8000_0000
) (
  input  logic                 clk,
  input  logic                 reset_i,
  input  bpu_pkg::inst_t       inst_data_i,
  input  logic                 inst_valid_i,
  input  bpu_pkg::xlen_t       update_pc_i,
  input  logic                 update_valid_i,
  input  logic                 update_taken_i,
  input  bpu_pkg::jump_type_t  update_jump_type_i,
  input  logic                 redirect_valid_i,
  input  bpu_pkg::xlen_t       redirect_pc_i,
  output bpu_pkg::xlen_t       pc_if_o,
  output logic                 pred_taken_o
);

  logic           pred_valid;
  bpu_pkg::xlen_t pred_op1;
  bpu_pkg::xlen_t pred_op2;

  bpu_predict #(
    .BHT_NUM (BHT_NUM)
  ) u_bpu_predict (
    .clk                (clk),
    .reset_i            (reset_i),
    .inst_data_i        (inst_data_i),
    .pc_if_i            (pc_if_o),
    .update_pc_i        (update_pc_i),
    .update_valid_i     (update_valid_i),
    .update_taken_i     (update_taken_i),
    .update_jump_type_i (update_jump_type_i),
    .pred_valid_o       (pred_valid),
    .pred_op1_o         (pred_op1),
    .pred_op2_o         (pred_op2)
  );

  // a fetched instruction is a step, a low valid stalls the pc
  fetch_pc_gen #(
    .RESET_PC (RESET_PC)
  ) u_fetch_pc_gen (
    .clk              (clk),
    .reset_i          (reset_i),
    .step_i           (inst_valid_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .pred_valid_i     (pred_valid),
    .pred_op1_i       (pred_op1),
    .pred_op2_i       (pred_op2),
    .pc_o             (pc_if_o)
  );

  assign pred_taken_o = pred_valid;

endmodule

// ==== tests/bpu_frontend_props.sv ====
`timescale 1ns/1ps

module fetch_pc_gen_props (
  input logic           clk,
  input logic           reset_i,
  input logic           step_i,
  input logic           redirect_valid_i,
  input bpu_pkg::xlen_t redirect_pc_i,
  input bpu_pkg::xlen_t pc_o
);

  // no compressed fetch, so the pc stays on word boundaries
  a_aligned: assert property (@(posedge clk) disable iff (reset_i)
    pc_o[1:0] == 2'b00)
    else $error("fetch pc is not word aligned");

  a_hold: assert property (@(posedge clk) disable iff (reset_i)
    (!step_i && !redirect_valid_i) |=> $stable(pc_o))
    else $error("fetch pc moved without a step or a redirect");

  a_redirect: assert property (@(posedge clk) disable iff (reset_i)
    redirect_valid_i |=> (pc_o == $past(redirect_pc_i)))
    else $error("redirect pc was not loaded");

endmodule

bind fetch_pc_gen fetch_pc_gen_props u_props (
  .clk              (clk),
  .reset_i          (reset_i),
  .step_i           (step_i),
  .redirect_valid_i (redirect_valid_i),
  .redirect_pc_i    (redirect_pc_i),
  .pc_o             (pc_o)
);

// ==== tests/bpu_frontend_tb.sv ====
`timescale 1ns/1ps

module bpu_frontend_tb;

  localparam bpu_pkg::xlen_t      RESET_PC     = 64'h8000_0000;
  localparam bpu_pkg::xlen_t      TRAIN_PC     = 64'h8000_2000;
  localparam bpu_pkg::jump_type_t JT_BR        = 5'b0_0001;
  localparam bpu_pkg::jump_type_t JT_JL        = 5'b0_0100;
  localparam int                  RESET_CYCLES = 10;

  // zero in the inst column asks for a random filler word
  typedef struct packed {
    bpu_pkg::inst_t      inst;
    logic                valid;
    logic                upd_valid;
    logic                upd_taken;
    bpu_pkg::jump_type_t upd_jt;
    bpu_pkg::xlen_t      upd_pc;
    logic                redir_valid;
    bpu_pkg::xlen_t      redir_pc;
    logic                exp_pred;
    bpu_pkg::xlen_t      exp_pc;
  } row_t;

  logic                clk;
  logic                reset_i;
  bpu_pkg::inst_t      inst_data_i;
  logic                inst_valid_i;
  bpu_pkg::xlen_t      update_pc_i;
  logic                update_valid_i;
  logic                update_taken_i;
  bpu_pkg::jump_type_t update_jump_type_i;
  logic                redirect_valid_i;
  bpu_pkg::xlen_t      redirect_pc_i;
  bpu_pkg::xlen_t      pc_if_o;
  logic                pred_taken_o;

  row_t        rows[$];
  // update and redirect waiting for the next row
  row_t        pend;
  logic [31:0] lfsr_q;
  int          n_checks;
  int          n_errors;
  int          cycles;
  int          cycle_limit;

  bpu_frontend_top #(
    .BHT_NUM  (64),
    .RESET_PC (RESET_PC)
  ) dut0 (
    .clk                (clk),
    .reset_i            (reset_i),
    .inst_data_i        (inst_data_i),
    .inst_valid_i       (inst_valid_i),
    .update_pc_i        (update_pc_i),
    .update_valid_i     (update_valid_i),
    .update_taken_i     (update_taken_i),
    .update_jump_type_i (update_jump_type_i),
    .redirect_valid_i   (redirect_valid_i),
    .redirect_pc_i      (redirect_pc_i),
    .pc_if_o            (pc_if_o),
    .pred_taken_o       (pred_taken_o)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run still busy after %0d cycles", cycles);
      $display("tests failed");
      $finish;
    end
  end

  // fibonacci taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // OP-IMM word with one lfsr step per random bit
  task automatic make_filler(output bpu_pkg::inst_t w);
    logic [24:0] bits;
    int          i;
    for (i = 0; i < 25; i++) begin
      lfsr_q  = lfsr_next(lfsr_q);
      bits[i] = lfsr_q[0];
    end
    w = {bits, 7'b001_0011};
  endtask

  // jal x1, imm
  function automatic bpu_pkg::inst_t enc_jal(input int imm);
    logic [20:0] v;
    v = imm[20:0];
    return {v[20], v[10:1], v[11], v[19:12], 5'd1, 7'b110_1111};
  endfunction

  function automatic bpu_pkg::inst_t enc_jalr(input logic [4:0] rs1, input int imm);
    logic [11:0] v;
    v = imm[11:0];
    return {v, rs1, 3'b000, 5'd0, 7'b110_0111};
  endfunction

  // beq x0, x0, imm
  function automatic bpu_pkg::inst_t enc_branch(input int imm);
    logic [12:0] v;
    v = imm[12:0];
    return {v[12], v[10:5], 5'd0, 5'd0, 3'b000, v[4:1], v[11], 7'b110_0011};
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
    n_checks++;
    if (got !== expected) begin
      n_errors++;
      $display("[ERROR] %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic set_update(input bpu_pkg::xlen_t pc, input logic taken,
                            input bpu_pkg::jump_type_t jt);
    pend.upd_valid = 1'b1;
    pend.upd_pc    = pc;
    pend.upd_taken = taken;
    pend.upd_jt    = jt;
  endtask

  task automatic set_redirect(input bpu_pkg::xlen_t pc);
    pend.redir_valid = 1'b1;
    pend.redir_pc    = pc;
  endtask

  task automatic add_row(input bpu_pkg::inst_t inst, input logic valid,
                         input logic exp_pred, input bpu_pkg::xlen_t exp_pc);
    row_t r;
    r          = pend;
    r.inst     = inst;
    r.valid    = valid;
    r.exp_pred = exp_pred;
    r.exp_pc   = exp_pc;
    rows.push_back(r);
    pend = '0;
  endtask

  task automatic build_table();
    // sequential fetch after reset
    add_row('0, 1'b1, 1'b0, 64'h8000_0004);
    add_row('0, 1'b1, 1'b0, 64'h8000_0008);
    add_row('0, 1'b1, 1'b0, 64'h8000_000c);
    // jal, jalr from x0 with both signs, jalr from x5
    add_row(enc_jal('h40), 1'b1, 1'b1, 64'h8000_004c);
    add_row(enc_jalr(5'd0, 'h100), 1'b1, 1'b1, 64'h0000_0100);
    add_row(enc_jalr(5'd5, 8), 1'b1, 1'b0, 64'h0000_0104);
    add_row(enc_jalr(5'd0, -16), 1'b1, 1'b1, 64'hffff_ffff_ffff_fff0);
    set_redirect(64'h8000_1000);
    add_row('0, 1'b1, 1'b0, 64'h8000_1000);
    // empty table gives backward taken and forward not taken
    add_row(enc_branch(-'h20), 1'b1, 1'b1, 64'h8000_0fe0);
    add_row(enc_branch('h20), 1'b1, 1'b0, 64'h8000_0fe4);
    // training where the lookup in an update cycle still sees the old counter
    set_redirect(TRAIN_PC);
    set_update(TRAIN_PC, 1'b0, JT_BR);
    add_row('0, 1'b1, 1'b0, TRAIN_PC);
    set_update(TRAIN_PC, 1'b1, JT_BR);
    add_row(enc_branch(-'h40), 1'b1, 1'b0, 64'h8000_2004);
    set_redirect(TRAIN_PC);
    add_row('0, 1'b1, 1'b0, TRAIN_PC);
    set_update(TRAIN_PC, 1'b1, JT_BR);
    add_row(enc_branch(-'h40), 1'b1, 1'b1, 64'h8000_1fc0);
    set_redirect(TRAIN_PC);
    set_update(TRAIN_PC, 1'b0, JT_BR);
    add_row('0, 1'b1, 1'b0, TRAIN_PC);
    add_row(enc_branch(-'h40), 1'b1, 1'b1, 64'h8000_1fc0);
    // stall holds the pc and a jal update does not train the table
    set_update(TRAIN_PC, 1'b0, JT_JL);
    add_row('0, 1'b0, 1'b0, 64'h8000_1fc0);
    add_row(enc_jal('h40), 1'b0, 1'b1, 64'h8000_1fc0);
    set_redirect(64'h8000_3000);
    add_row(enc_jal('h40), 1'b1, 1'b1, 64'h8000_3000);
    set_redirect(64'h8000_4000);
    add_row(enc_jal('h40), 1'b0, 1'b1, 64'h8000_4000);
    add_row('0, 1'b1, 1'b0, 64'h8000_4004);
    set_redirect(TRAIN_PC);
    add_row('0, 1'b1, 1'b0, TRAIN_PC);
    add_row(enc_branch(-'h40), 1'b1, 1'b1, 64'h8000_1fc0);
  endtask

  task automatic apply_row(input row_t r);
    bpu_pkg::inst_t w;
    if (r.inst == '0) begin
      make_filler(w);
    end else begin
      w = r.inst;
    end
    inst_data_i        = w;
    inst_valid_i       = r.valid;
    update_valid_i     = r.upd_valid;
    update_taken_i     = r.upd_taken;
    update_jump_type_i = r.upd_jt;
    update_pc_i        = r.upd_pc;
    redirect_valid_i   = r.redir_valid;
    redirect_pc_i      = r.redir_pc;
    // prediction is combinational so look in the middle of the low phase
    #5;
    compare_value("pred_taken_o", 64'(pred_taken_o), 64'(r.exp_pred));
    @(negedge clk);
    compare_value("pc_if_o", pc_if_o, r.exp_pc);
  endtask

  initial begin
    clk                = 1'b0;
    reset_i            = 1'b1;
    inst_data_i        = '0;
    inst_valid_i       = 1'b0;
    update_pc_i        = '0;
    update_valid_i     = 1'b0;
    update_taken_i     = 1'b0;
    update_jump_type_i = '0;
    redirect_valid_i   = 1'b0;
    redirect_pc_i      = '0;
    lfsr_q             = 32'h0b81_e0be;
    n_checks           = 0;
    n_errors           = 0;
    cycles             = 0;
    pend               = '0;
    build_table();
    cycle_limit = RESET_CYCLES + 4 * rows.size() + 50;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    compare_value("pc_if_o", pc_if_o, RESET_PC);
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    $display("checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
rtl/bpu_pkg.sv
rtl/bpu_update_if.sv
rtl/bpu_branch.sv
rtl/bpu_predict.sv
rtl/fetch_pc_gen.sv
rtl/bpu_frontend_top.sv
tests/bpu_frontend_props.sv
tests/bpu_frontend_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = bpu_frontend_tb
FILELIST = verilog.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
